// ==== build.f ====
+incdir+test
source/cpu_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_core.sv
test/cpu_core_tb.sv

// ==== test/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

////////////////////
// Shadow state
////////////////////
data_t model_regs [REG_COUNT];  // Updated in program order at acceptance
data_t model_mem  [MEM_WORDS];

// Destination of an instruction that will retire a record
typedef struct packed {
	logic      writes;
	reg_addr_t rd;
} pending_t;

task automatic model_clear();
	for (int i = 0; i < REG_COUNT; i++) model_regs[i] = '0;
	for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
endtask

// Sources read by an opcode, {rs1, rs2}
function automatic logic [1:0] sources_used(input opcode_t op);
	case (op)
		op_addi, op_ld: return 2'b10;
		op_nop:         return 2'b00;
		default:        return 2'b11;  // Register ALU ops and stores
	endcase
endfunction

// Runs one instruction on the shadow state, high when a record retires
function automatic logic model_exec(input instr_t word, output result_t rec,
	output pending_t dst);
	opcode_t   op;
	data_t     a;
	data_t     b;
	data_t     imm64;
	data_t     ea;
	mem_addr_t idx;
	op    = opcode_t'(word[31:28]);
	a     = model_regs[word[24:22]];
	b     = model_regs[word[21:19]];
	imm64 = {{48{word[15]}}, word[15:0]};  // Sign-extended immediate
	ea    = a + imm64;
	idx   = ea[3:0];                       // Memory wraps on the low bits
	rec        = '0;
	rec.op     = op;
	rec.rd     = word[27:25];
	dst.rd     = word[27:25];
	dst.writes = 1'b1;
	case (op)
		op_add:  rec.value = a + b;
		op_sub:  rec.value = a - b;
		op_and:  rec.value = a & b;
		op_or:   rec.value = a | b;
		op_xor:  rec.value = a ^ b;
		op_shl:  rec.value = a << b[5:0];
		op_shr:  rec.value = a >> b[5:0];
		op_addi: rec.value = ea;
		op_ld: begin
			rec.value = model_mem[idx];
			rec.addr  = idx;
		end
		op_st: begin
			model_mem[idx] = b;
			rec.value      = b;  // Stored word
			rec.addr       = idx;
			dst.writes     = 1'b0;
		end
		default: return 1'b0;  // nop, nothing retires
	endcase
	if (dst.writes) model_regs[dst.rd] = rec.value;
	return 1'b1;
endfunction

`endif

// ==== test/cpu_core_tb.sv ====
module cpu_core_tb
	import cpu_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int N_ALU        = 40;
	localparam int N_CHAIN      = 24;
	localparam int N_MEM        = 12;  // Per memory phase
	localparam int N_BP         = 48;
	localparam int TOTAL_INSTR  = REG_COUNT + N_ALU + N_CHAIN + 4 * N_MEM + N_BP;
	localparam int CYCLE_LIMIT  = 4 * TOTAL_INSTR + RESET_CYCLES + 400;

	logic    clk;
	logic    reset;
	logic    instr_valid;
	logic    instr_ready;
	instr_t  instr;
	logic    res_valid;
	logic    res_ready;
	result_t res;

	`include "cpu_model.svh"

	logic [15:0] lfsr_state;
	result_t     exp_q [$];       // Predicted records in program order
	pending_t    inflight_q [$];  // Matching destinations for the hazard rule
	logic        bp_pattern [512];
	int          bp_idx;
	logic        bp_enable;
	int          cycle_count;
	int          error_count;
	int          errors_at_start;
	int          tests_passed;
	int          tests_failed;
	logic        prev_stall;
	result_t     prev_res;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	cpu_core dut0 (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res)
	);

	////////////////////
	// Stimulus helpers
	////////////////////
	// Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v          = {v[62:0], fb};
		end
		return v;
	endfunction

	function automatic reg_addr_t random_reg();
		return 3'(rand_bits(3));
	endfunction

	function automatic logic [15:0] random_imm();
		return 16'(rand_bits(16));
	endfunction

	function automatic opcode_t random_alu_op();
		return opcode_t'(4'(1 + (rand_bits(8) % 7)));  // add through shr
	endfunction

	function automatic instr_t encode(input opcode_t op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2, input logic [15:0] imm);
		return {op, rd, rs1, rs2, 3'b000, imm};
	endfunction

	// Called on a falling edge and returns on the falling edge after the transfer
	task automatic send(input instr_t word);
		instr_valid = 1'b1;
		instr       = word;
		@(posedge clk);
		while (!instr_ready) @(posedge clk);
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	// Runs of ready high or low lasting 1 to 8 cycles
	task automatic build_bp_pattern();
		int   idx;
		int   len;
		logic level;
		idx = 0;
		while (idx < 512) begin
			level = 1'(rand_bits(1));
			len   = 1 + 32'(rand_bits(3));
			for (int k = 0; k < len && idx < 512; k++) begin
				bp_pattern[idx] = level;
				idx++;
			end
		end
	endtask

	task automatic compare_field(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Every field of a result record
	task automatic compare_record(input string prefix, input result_t expected,
		input result_t actual);
		compare_field({prefix, ".op"}, 64'(expected.op), 64'(actual.op));
		compare_field({prefix, ".rd"}, 64'(expected.rd), 64'(actual.rd));
		compare_field({prefix, ".value"}, expected.value, actual.value);
		compare_field({prefix, ".addr"}, 64'(expected.addr), 64'(actual.addr));
	endtask

	// Waits for the pipeline to drain and then reports the test
	task automatic finish_test(input string name);
		while (exp_q.size() != 0) @(negedge clk);
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	////////////////////
	// Result monitor
	////////////////////
	always @(posedge clk) begin : monitor
		result_t    rec;
		pending_t   dst;
		logic [1:0] used;
		logic       hazard;
		logic       exp_ready;
		if (!reset) begin
			if (prev_stall) begin  // Held by back-pressure last cycle
				compare_field("res_valid", 64'(1'b1), 64'(res_valid));
				compare_record("res", prev_res, res);
			end
			if (instr_valid) begin
				used   = sources_used(opcode_t'(instr[31:28]));
				hazard = 1'b0;
				foreach (inflight_q[i]) begin
					if (inflight_q[i].writes &&
						((used[1] && inflight_q[i].rd == instr[24:22]) ||
						(used[0] && inflight_q[i].rd == instr[21:19])))
						hazard = 1'b1;
				end
				exp_ready = (!res_valid || res_ready) && !hazard;
				compare_field("instr_ready", 64'(exp_ready), 64'(instr_ready));
			end
			if (res_valid && res_ready) begin
				if (exp_q.size() == 0) begin
					$display("Result retired at %0t with no instruction left to match it", $time);
					error_count++;
				end else begin
					rec = exp_q.pop_front();
					void'(inflight_q.pop_front());
					compare_record("res", rec, res);
				end
			end
			if (instr_valid && instr_ready) begin
				if (model_exec(instr, rec, dst)) begin  // nop retires nothing
					exp_q.push_back(rec);
					inflight_q.push_back(dst);
				end
			end
			prev_stall = res_valid && !res_ready;
			prev_res   = res;
		end
	end

	// Back-pressure source
	always @(negedge clk) begin
		if (bp_enable) begin
			res_ready = bp_pattern[bp_idx % 512];
			bp_idx++;
		end else begin
			res_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Pipeline hung, run stopped after %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////
	initial begin : sequence_main
		reg_addr_t   prev_rd;
		reg_addr_t   rd;
		reg_addr_t   base;
		logic [15:0] off;
		reg_addr_t   bases [N_MEM];
		logic [15:0] offsets [N_MEM];
		reset           = 1'b1;
		instr_valid     = 1'b0;
		instr           = '0;
		res_ready       = 1'b1;
		bp_enable       = 1'b0;
		bp_idx          = 0;
		lfsr_state      = 16'd37073;
		cycle_count     = 0;
		error_count     = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		prev_stall      = 1'b0;
		prev_res        = '0;
		model_clear();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		@(posedge clk);  // First cycle out of reset
		assert (!res_valid && instr_ready) else begin
			$display("Reset state wrong: res_valid %b, instr_ready %b", res_valid, instr_ready);
			error_count++;
		end
		@(negedge clk);
		finish_test("reset state");

		for (int r = 0; r < REG_COUNT; r++) begin
			send(encode(op_addi, 3'(r), 3'(r), 3'd0, random_imm()));  // rN still zero
		end
		for (int n = 0; n < N_ALU; n++) begin  // Cycles through add to shr
			send(encode(opcode_t'(4'(1 + n % 7)), random_reg(), random_reg(), random_reg(),
				16'h0));
		end
		finish_test("independent alu ops");

		prev_rd = random_reg();
		for (int n = 0; n < N_CHAIN; n++) begin  // Each reads the last destination
			rd = random_reg();
			if (n % 4 == 3) begin
				send(encode(op_addi, rd, prev_rd, 3'd0, random_imm()));
			end else begin
				send(encode(random_alu_op(), rd, prev_rd, (n % 2 == 1) ? prev_rd : random_reg(),
					16'h0));
			end
			prev_rd = rd;
		end
		finish_test("dependent chains");

		// Bases stay in r0 to r6 while loads land in r7
		for (int n = 0; n < N_MEM; n++) begin
			bases[n]   = 3'(rand_bits(8) % 7);
			offsets[n] = random_imm();
			send(encode(op_st, 3'd0, bases[n], random_reg(), offsets[n]));
		end
		for (int n = 0; n < N_MEM; n++) begin
			send(encode(op_ld, 3'd7, bases[n], 3'd0, offsets[n]));
		end
		for (int n = 0; n < N_MEM; n++) begin  // Load right behind its store
			base = 3'(rand_bits(8) % 7);
			off  = random_imm();
			send(encode(op_st, 3'd0, base, random_reg(), off));
			send(encode(op_ld, 3'd7, base, 3'd0, off));
		end
		finish_test("store and load");

		build_bp_pattern();
		bp_enable = 1'b1;
		for (int n = 0; n < N_BP; n++) begin  // Any opcode including nop
			send(encode(opcode_t'(4'(rand_bits(8) % 11)), random_reg(), random_reg(),
				random_reg(), random_imm()));
		end
		finish_test("back-pressure");
		bp_enable = 1'b0;

		repeat (8) @(negedge clk);  // Stray records would show up here
		finish_test("idle after drain");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== source/cpu_core.sv ====
module cpu_core
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,

	// Instruction input
	input  logic    instr_valid,
	output logic    instr_ready,
	input  instr_t  instr,

	// Retired results
	output logic    res_valid,
	input  logic    res_ready,
	output result_t res
);

	logic      advance;  // Shared enable for all pipeline registers

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	data_t     rs1_data;
	data_t     rs2_data;

	idex_t     idex;
	exmem_t    exmem;

	logic      wb_en;
	reg_addr_t wb_rd;
	data_t     wb_data;
	logic      wb_pending;
	reg_addr_t wb_pending_rd;

	// Freeze everything while a result waits on the output
	assign advance = !res_valid || res_ready;

	////////////////////
	// Stages
	////////////////////
	register_file regfile0 (
		.clk      (clk),
		.reset    (reset),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	decode_stage decode0 (
		.clk           (clk),
		.reset         (reset),
		.advance       (advance),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.instr         (instr),
		.rs1_addr      (rs1_addr),
		.rs2_addr      (rs2_addr),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.exmem         (exmem),
		.wb_pending    (wb_pending),
		.wb_pending_rd (wb_pending_rd),
		.idex          (idex)
	);

	execute_stage execute0 (
		.clk     (clk),
		.reset   (reset),
		.advance (advance),
		.idex    (idex),
		.exmem   (exmem)
	);

	result_stage result0 (
		.clk           (clk),
		.reset         (reset),
		.advance       (advance),
		.exmem         (exmem),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.res           (res),
		.wb_en         (wb_en),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.wb_pending    (wb_pending),
		.wb_pending_rd (wb_pending_rd)
	);

endmodule

// ==== source/result_stage.sv ====
module result_stage
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      advance,     // Global pipeline enable
	input  exmem_t    exmem,

	// Result handshake
	output logic      res_valid,
	input  logic      res_ready,
	output result_t   res,

	// Register file write port
	output logic      wb_en,
	output reg_addr_t wb_rd,
	output data_t     wb_data,

	// MEM/WB destination for the hazard check
	output logic      wb_pending,
	output reg_addr_t wb_pending_rd
);

	data_t     mem [MEM_WORDS];  // Data memory

	mem_addr_t mem_idx;
	data_t     mem_rdata;
	logic      wb_writes;        // MEM/WB record writes a register
	logic      is_mem_op;
	result_t   res_next;

	assign mem_idx   = exmem.alu_result[MEM_AW-1:0];  // Low bits of the address
	assign mem_rdata = mem[mem_idx];
	assign is_mem_op = (exmem.op == op_ld) || (exmem.op == op_st);

	////////////////////
	// Data memory
	////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (advance && exmem.valid && exmem.mem_write_enable) begin
			mem[mem_idx] <= exmem.mem_write_data;  // Store on the advancing edge
		end
	end

	// Result record
	always_comb begin
		res_next    = '0;
		res_next.op = exmem.op;
		res_next.rd = exmem.rd;
		case (exmem.op)
			op_ld:   res_next.value = mem_rdata;
			op_st:   res_next.value = exmem.mem_write_data;
			default: res_next.value = exmem.alu_result;
		endcase
		res_next.addr = is_mem_op ? mem_idx : '0;
	end

	////////////////////
	// MEM/WB register
	////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			res_valid <= 1'b0;
			wb_writes <= 1'b0;
			res       <= '0;
		end else if (advance) begin
			// Bubbles and no-ops produce no result
			res_valid <= exmem.valid && (exmem.op != op_nop);
			wb_writes <= exmem.valid && exmem.writes_reg;
			res       <= res_next;
		end
	end

	// Writeback on the transfer edge
	assign wb_en   = res_valid && res_ready && wb_writes;
	assign wb_rd   = res.rd;
	assign wb_data = res.value;

	assign wb_pending    = res_valid && wb_writes;
	assign wb_pending_rd = res.rd;

endmodule

// ==== source/execute_stage.sv ====
module execute_stage
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   advance,  // Global pipeline enable
	input  idex_t  idex,
	output exmem_t exmem
);

	data_t                a;
	data_t                b;
	logic [SHAMT_W-1:0]   shamt;
	data_t                alu_result;
	logic                 mem_write_enable;
	exmem_t               exmem_next;

	assign a     = idex.operand_a;
	assign b     = idex.operand_b;
	assign shamt = b[SHAMT_W-1:0];  // 0 to 63

	////////////////////
	// ALU
	////////////////////
	always_comb begin
		case (idex.op)
			op_add: begin
				alu_result = a + b;
			end
			op_sub: begin
				alu_result = a - b;
			end
			op_and: begin
				alu_result = a & b;
			end
			op_or: begin
				alu_result = a | b;
			end
			op_xor: begin
				alu_result = a ^ b;
			end
			op_shl: begin
				alu_result = a << shamt;
			end
			op_shr: begin
				alu_result = a >> shamt;  // Zero fill
			end
			op_addi, op_ld, op_st: begin
				// b already holds the sign-extended immediate
				alu_result = a + b;
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

	// Only a live store may touch memory
	assign mem_write_enable = idex.valid && (idex.op == op_st);

	////////////////////
	// EX/MEM record
	////////////////////
	always_comb begin
		exmem_next                  = '0;
		exmem_next.valid            = idex.valid;
		exmem_next.op               = idex.op;
		exmem_next.rd               = idex.rd;
		exmem_next.writes_reg       = idex.writes_reg;
		exmem_next.alu_result       = alu_result;  // Effective address for ld/st
		exmem_next.mem_write_data   = idex.store_data;
		exmem_next.mem_write_enable = mem_write_enable;
	end

	// EX/MEM pipeline register, holds on back-pressure
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exmem <= '0;  // Valid and write enable low
		end else if (advance) begin
			exmem <= exmem_next;
		end
	end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      advance,        // Global pipeline enable

	// Instruction handshake
	input  logic      instr_valid,
	output logic      instr_ready,
	input  instr_t    instr,

	// Register file read
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	input  data_t     rs1_data,
	input  data_t     rs2_data,

	// In-flight destinations for the hazard check
	input  exmem_t    exmem,
	input  logic      wb_pending,
	input  reg_addr_t wb_pending_rd,

	output idex_t     idex
);

	instr_fields_t f;

	logic  legal;       // Opcode produces a pipeline record
	logic  uses_rs1;
	logic  uses_rs2;
	logic  writes_reg;
	logic  imm_op;      // Operand b from immediate
	logic  hazard;
	logic  accept;
	data_t imm_ext;
	idex_t idex_next;

	// True when a valid writing entry targets a source we read
	function automatic logic src_hit(
		input logic      entry_valid,
		input reg_addr_t entry_rd,
		input reg_addr_t src1,
		input reg_addr_t src2,
		input logic      use1,
		input logic      use2
	);
		logic hit;
		hit = (use1 && (src1 == entry_rd)) || (use2 && (src2 == entry_rd));
		return entry_valid && hit;
	endfunction

	assign f = instr_fields_t'(instr);

	////////////////////
	// Field decode
	////////////////////
	always_comb begin
		legal      = 1'b0;
		uses_rs1   = 1'b0;
		uses_rs2   = 1'b0;
		writes_reg = 1'b0;
		imm_op     = 1'b0;
		case (f.op)
			op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
				legal      = 1'b1;
				uses_rs1   = 1'b1;
				uses_rs2   = 1'b1;
				writes_reg = 1'b1;
			end
			op_addi, op_ld: begin
				legal      = 1'b1;
				uses_rs1   = 1'b1;
				writes_reg = 1'b1;
				imm_op     = 1'b1;
			end
			op_st: begin
				legal    = 1'b1;
				uses_rs1 = 1'b1;  // Base
				uses_rs2 = 1'b1;  // Store data
				imm_op   = 1'b1;
			end
			default: ;  // nop and unused codes go through as bubbles
		endcase
	end

	assign rs1_addr = f.rs1;
	assign rs2_addr = f.rs2;

	////////////////////
	// RAW hazard against ID/EX, EX/MEM and MEM/WB
	////////////////////
	assign hazard =
		src_hit(idex.valid && idex.writes_reg, idex.rd, f.rs1, f.rs2, uses_rs1, uses_rs2) ||
		src_hit(exmem.valid && exmem.writes_reg, exmem.rd, f.rs1, f.rs2, uses_rs1, uses_rs2) ||
		src_hit(wb_pending, wb_pending_rd, f.rs1, f.rs2, uses_rs1, uses_rs2);

	assign instr_ready = advance && !hazard;
	assign accept      = instr_valid && instr_ready;

	assign imm_ext = {{(DATA_W-IMM_W){f.imm[IMM_W-1]}}, f.imm};

	always_comb begin
		idex_next            = '0;  // Bubble unless accepted
		idex_next.valid      = accept && legal;
		idex_next.op         = f.op;
		idex_next.rd         = f.rd;
		idex_next.writes_reg = writes_reg;
		idex_next.operand_a  = rs1_data;
		idex_next.operand_b  = imm_op ? imm_ext : rs2_data;
		idex_next.store_data = rs2_data;
	end

	// ID/EX register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idex <= '0;
		end else if (advance) begin
			idex <= idex_next;  // Stall inserts a bubble here
		end
	end

endmodule

// ==== source/register_file.sv ====
module register_file
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	// Read ports, combinational
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	output data_t     rs1_data,
	output data_t     rs2_data,

	// Write port from result stage
	input  logic      wb_en,
	input  reg_addr_t wb_rd,
	input  data_t     wb_data
);

	data_t regs [REG_COUNT];

	logic  bypass1;  // Same-cycle write hits read port 1
	logic  bypass2;

	////////////////////
	// Write port
	////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;  // All registers read zero out of reset
			end
		end else if (wb_en) begin
			regs[wb_rd] <= wb_data;
		end
	end

	////////////////////
	// Read ports with write-first bypass
	////////////////////
	assign bypass1 = wb_en && (wb_rd == rs1_addr);
	assign bypass2 = wb_en && (wb_rd == rs2_addr);

	// Decode sees the value being written this cycle
	assign rs1_data = bypass1 ? wb_data : regs[rs1_addr];
	assign rs2_data = bypass2 ? wb_data : regs[rs2_addr];

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	////////////////////
	// Widths and sizes
	////////////////////
	localparam int DATA_W    = 64;
	localparam int INSTR_W   = 32;
	localparam int IMM_W     = 16;
	localparam int REG_COUNT = 8;
	localparam int MEM_WORDS = 16;
	localparam int REG_AW    = $clog2(REG_COUNT);  // 3 bits
	localparam int MEM_AW    = $clog2(MEM_WORDS);  // 4 bits
	localparam int SHAMT_W   = 6;                  // Low bits of operand b for shifts

	typedef logic [DATA_W-1:0]         data_t;      // Register or memory word
	typedef logic [REG_AW-1:0]         reg_addr_t;  // Register index
	typedef logic [MEM_AW-1:0]         mem_addr_t;  // Data memory word index
	typedef logic signed [IMM_W-1:0]   imm_t;       // Sign extended in decode
	typedef logic [INSTR_W-1:0]        instr_t;     // Raw instruction word

	typedef enum logic [3:0] {
		op_nop  = 4'd0,   // Bubble, no result
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_shl  = 4'd6,
		op_shr  = 4'd7,   // Logical
		op_addi = 4'd8,
		op_ld   = 4'd9,   // rd <= mem[rs1 + imm]
		op_st   = 4'd10   // mem[rs1 + imm] <= rs2
	} opcode_t;

	////////////////////
	// Instruction layout, msb first
	////////////////////
	typedef struct packed {
		opcode_t   op;     // 31:28
		reg_addr_t rd;     // 27:25
		reg_addr_t rs1;    // 24:22
		reg_addr_t rs2;    // 21:19
		logic [2:0] spare; // 18:16 unused
		imm_t      imm;    // 15:0
	} instr_fields_t;

	////////////////////
	// Stage records
	////////////////////
	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		logic      writes_reg;
		data_t     operand_a;   // rs1
		data_t     operand_b;   // rs2 or immediate
		data_t     store_data;  // rs2 for stores
	} idex_t;

	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		logic      writes_reg;
		data_t     alu_result;        // Also effective address for ld/st
		data_t     mem_write_data;
		logic      mem_write_enable;
	} exmem_t;

	typedef struct packed {
		opcode_t   op;
		reg_addr_t rd;
		data_t     value;  // ALU result, loaded or stored word
		mem_addr_t addr;   // Memory index for ld/st, else zero
	} result_t;

endpackage
